//--- source/mips_consts.svh
`ifndef MIPS_CONSTS_SVH
`define MIPS_CONSTS_SVH

`define MIPS_XLEN          32 // Data path width
`define MIPS_NUM_REGS      32 // General purpose registers
`define MIPS_INSTR_CREDITS 2  // Sender credits, also the queue depth
`define MIPS_MUL_STEPS     32 // One add-and-shift per multiplier bit

`endif

//--- source/mips_pkg.sv
`include "mips_consts.svh"

package mips_pkg;

	typedef struct packed {
		logic [5:0] op;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;    // Top of the immediate for I-type
		logic [4:0] shamt;
		logic [5:0] funct;
	} instr_t;

	typedef enum logic [5:0] {
		OP_SPECIAL = 6'h00, OP_ADDI = 6'h08, OP_ADDIU = 6'h09, OP_SLTI = 6'h0a,
		OP_SLTIU = 6'h0b, OP_ANDI = 6'h0c, OP_ORI = 6'h0d, OP_XORI = 6'h0e,
		OP_LUI = 6'h0f
	} opcode_e;

	typedef enum logic [5:0] {
		F_SLL = 6'h00, F_SRL = 6'h02, F_SRA = 6'h03,
		F_MFHI = 6'h10, F_MTHI = 6'h11, F_MFLO = 6'h12, F_MTLO = 6'h13,
		F_MULT = 6'h18, F_MULTU = 6'h19,
		F_ADD = 6'h20, F_ADDU = 6'h21, F_SUB = 6'h22, F_SUBU = 6'h23,
		F_AND = 6'h24, F_OR = 6'h25, F_XOR = 6'h26, F_NOR = 6'h27,
		F_SLT = 6'h2a, F_SLTU = 6'h2b
	} funct_e;

	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR, ALU_NOR, ALU_SLT, ALU_SLTU,
		ALU_SLL, ALU_SRL, ALU_SRA, ALU_LUI, ALU_PASS_A, ALU_PASS_HI, ALU_PASS_LO
	} alu_op_e;

	typedef struct packed {
		logic    reg_write;
		logic    use_imm;    // Operand B from the immediate
		logic    zero_ext;
		logic    dst_rd;     // Destination rd, otherwise rt
		logic    hi_we;
		logic    lo_we;
		logic    mul;
		logic    mul_signed;
		alu_op_e alu_op;
		logic    illegal;
	} ctrl_t;

	typedef enum logic [2:0] {
		RET_GPR, RET_HI, RET_LO, RET_HILO, RET_ILLEGAL
	} retire_kind_e;

	// Fields that a kind does not write read as zero
	typedef struct packed {
		retire_kind_e          kind;
		logic [4:0]            dest;
		logic [`MIPS_XLEN-1:0] data_lo;
		logic [`MIPS_XLEN-1:0] data_hi;
	} retire_t;

	typedef enum logic [1:0] {
		S_IDLE, S_EXECUTE, S_MUL_STEP, S_WRITEBACK
	} seq_state_e;

endpackage

//--- source/mips_instr_queue.sv
`include "mips_consts.svh"

module mips_instr_queue
	import mips_pkg::*;
(
	input  logic   clk,
	input  logic   rst_n,
	input  logic   instr_valid,
	input  instr_t instr,
	input  logic   pop,
	output instr_t head,
	output logic   not_empty,
	output logic   credit_return
);
	localparam int DEPTH = `MIPS_INSTR_CREDITS;
	localparam int AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;

	instr_t                     mem [DEPTH];
	logic [AW-1:0]              wr_ptr;
	logic [AW-1:0]              rd_ptr;
	logic [$clog2(DEPTH+1)-1:0] count;
	logic                       do_pop;

	assign do_pop    = pop && not_empty;
	assign not_empty = (count != '0);
	assign head      = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (instr_valid) begin
			mem[wr_ptr] <= instr;
		end
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wr_ptr        <= '0;
			rd_ptr        <= '0;
			count         <= '0;
			credit_return <= 1'b0;
		end else begin
			if (instr_valid) begin
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			end
			if (instr_valid && !do_pop) begin
				count <= count + 1'b1;
			end else if (!instr_valid && do_pop) begin
				count <= count - 1'b1;
			end
			credit_return <= do_pop; // One credit back per entry freed
		end
	end

	// Sender must stay within its credits, so a full queue never sees a push
	assert property (@(posedge clk) disable iff (!rst_n)
		!(instr_valid && count == DEPTH));

endmodule

//--- source/mips_decoder.sv
module mips_decoder
	import mips_pkg::*;
(
	input  instr_t instr,
	output ctrl_t  ctrl
);

	always_comb begin
		ctrl        = '0;
		ctrl.alu_op = ALU_PASS_A;
		case (opcode_e'(instr.op))
			OP_SPECIAL: begin
				ctrl.reg_write = 1'b1;
				ctrl.dst_rd    = 1'b1;
				case (funct_e'(instr.funct))
					F_SLL:         ctrl.alu_op = ALU_SLL;
					F_SRL:         ctrl.alu_op = ALU_SRL;
					F_SRA:         ctrl.alu_op = ALU_SRA;
					F_ADD, F_ADDU: ctrl.alu_op = ALU_ADD; // No overflow trap
					F_SUB, F_SUBU: ctrl.alu_op = ALU_SUB;
					F_AND:         ctrl.alu_op = ALU_AND;
					F_OR:          ctrl.alu_op = ALU_OR;
					F_XOR:         ctrl.alu_op = ALU_XOR;
					F_NOR:         ctrl.alu_op = ALU_NOR;
					F_SLT:         ctrl.alu_op = ALU_SLT;
					F_SLTU:        ctrl.alu_op = ALU_SLTU;
					F_MFHI:        ctrl.alu_op = ALU_PASS_HI;
					F_MFLO:        ctrl.alu_op = ALU_PASS_LO;
					F_MTHI: begin
						ctrl.reg_write = 1'b0;
						ctrl.hi_we     = 1'b1; // rs passes through the ALU
					end
					F_MTLO: begin
						ctrl.reg_write = 1'b0;
						ctrl.lo_we     = 1'b1;
					end
					F_MULT, F_MULTU: begin
						ctrl.reg_write  = 1'b0;
						ctrl.hi_we      = 1'b1;
						ctrl.lo_we      = 1'b1;
						ctrl.mul        = 1'b1;
						ctrl.mul_signed = (instr.funct == F_MULT);
					end
					default: begin // Jumps, division and the rest
						ctrl.reg_write = 1'b0;
						ctrl.dst_rd    = 1'b0;
						ctrl.illegal   = 1'b1;
					end
				endcase
			end
			OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm   = 1'b1; // Sign-extended immediate
				if (instr.op == OP_SLTI) begin
					ctrl.alu_op = ALU_SLT;
				end else if (instr.op == OP_SLTIU) begin
					ctrl.alu_op = ALU_SLTU;
				end else begin
					ctrl.alu_op = ALU_ADD;
				end
			end
			OP_ANDI, OP_ORI, OP_XORI, OP_LUI: begin
				ctrl.reg_write = 1'b1;
				ctrl.use_imm   = 1'b1;
				ctrl.zero_ext  = 1'b1;
				case (opcode_e'(instr.op))
					OP_ANDI: ctrl.alu_op = ALU_AND;
					OP_ORI:  ctrl.alu_op = ALU_OR;
					OP_XORI: ctrl.alu_op = ALU_XOR;
					default: ctrl.alu_op = ALU_LUI;
				endcase
			end
			default: ctrl.illegal = 1'b1; // Loads, stores, branches, jumps
		endcase

		assert (!(ctrl.illegal && (ctrl.reg_write || ctrl.hi_we || ctrl.lo_we)));
	end

endmodule

//--- source/mips_alu.sv
`include "mips_consts.svh"

module mips_alu
	import mips_pkg::*;
(
	input  alu_op_e               op,
	input  logic [`MIPS_XLEN-1:0] a,
	input  logic [`MIPS_XLEN-1:0] b,
	input  logic [4:0]            shamt,
	input  logic [`MIPS_XLEN-1:0] hi,
	input  logic [`MIPS_XLEN-1:0] lo,
	output logic [`MIPS_XLEN-1:0] result
);
	localparam int XLEN = `MIPS_XLEN;

	always_comb begin
		case (op)
			ALU_ADD:     result = a + b;
			ALU_SUB:     result = a - b;
			ALU_AND:     result = a & b;
			ALU_OR:      result = a | b;
			ALU_XOR:     result = a ^ b;
			ALU_NOR:     result = ~(a | b);
			ALU_SLT:     result = XLEN'($signed(a) < $signed(b));
			ALU_SLTU:    result = XLEN'(a < b);
			ALU_SLL:     result = b << shamt; // Shifts act on rt
			ALU_SRL:     result = b >> shamt;
			ALU_SRA:     result = $signed(b) >>> shamt;
			ALU_LUI:     result = b << 16;
			ALU_PASS_HI: result = hi;
			ALU_PASS_LO: result = lo;
			default:     result = a; // Covers pass_a for mthi and mtlo
		endcase
	end

endmodule

//--- source/mips_regfile.sv
`include "mips_consts.svh"

module mips_regfile (
	input  logic                              clk,
	input  logic                              rst_n,
	input  logic [$clog2(`MIPS_NUM_REGS)-1:0] rs_addr,
	input  logic [$clog2(`MIPS_NUM_REGS)-1:0] rt_addr,
	output logic [`MIPS_XLEN-1:0]             rs_data,
	output logic [`MIPS_XLEN-1:0]             rt_data,
	input  logic                              wr_en,
	input  logic [$clog2(`MIPS_NUM_REGS)-1:0] wr_addr,
	input  logic [`MIPS_XLEN-1:0]             wr_data,
	input  logic                              hi_we,
	input  logic                              lo_we,
	input  logic [`MIPS_XLEN-1:0]             hi_in,
	input  logic [`MIPS_XLEN-1:0]             lo_in,
	output logic [`MIPS_XLEN-1:0]             hi,
	output logic [`MIPS_XLEN-1:0]             lo
);
	logic [`MIPS_XLEN-1:0] regs [`MIPS_NUM_REGS];

	assign rs_data = regs[rs_addr];
	assign rt_data = regs[rt_addr];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			for (int i = 0; i < `MIPS_NUM_REGS; i++) begin
				regs[i] <= '0;
			end
			hi <= '0;
			lo <= '0;
		end else begin
			if (wr_en && wr_addr != '0) begin
				regs[wr_addr] <= wr_data; // r0 stays zero
			end
			if (hi_we) begin
				hi <= hi_in;
			end
			if (lo_we) begin
				lo <= lo_in;
			end
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) regs[0] == '0);

endmodule

//--- source/mips_multiplier.sv
`include "mips_consts.svh"

module mips_multiplier (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  start,
	input  logic                  step_en,
	input  logic                  signed_mul,
	input  logic [`MIPS_XLEN-1:0] a,
	input  logic [`MIPS_XLEN-1:0] b,
	output logic [`MIPS_XLEN-1:0] product_hi,
	output logic [`MIPS_XLEN-1:0] product_lo
);
	localparam int XLEN = `MIPS_XLEN;

	logic [XLEN-1:0]   mcand;  // Multiplicand magnitude
	logic [2*XLEN-1:0] prod;   // Partial sum above, unused multiplier bits below
	logic [XLEN:0]     sum;
	logic [2*XLEN-1:0] result;
	logic              negate;

	assign sum        = {1'b0, prod[2*XLEN-1:XLEN]} + (prod[0] ? {1'b0, mcand} : '0);
	assign result     = negate ? -prod : prod;
	assign product_hi = result[2*XLEN-1:XLEN];
	assign product_lo = result[XLEN-1:0];

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			negate <= 1'b0;
		end else if (start) begin
			negate <= signed_mul && (a[XLEN-1] ^ b[XLEN-1]);
		end
	end

	always_ff @(posedge clk) begin
		if (start) begin
			mcand <= (signed_mul && a[XLEN-1]) ? -a : a;
			prod  <= {{XLEN{1'b0}}, (signed_mul && b[XLEN-1]) ? -b : b};
		end else if (step_en) begin
			prod <= {sum, prod[XLEN-1:1]}; // Add then shift right one
		end
	end

endmodule

//--- source/mips_step_timer.sv
`include "mips_consts.svh"

module mips_step_timer (
	input  logic clk,
	input  logic rst_n,
	input  logic load,
	input  logic step_en,
	output logic last_step
);
	localparam int CW = $clog2(`MIPS_MUL_STEPS);

	logic [CW-1:0] count; // Steps left after the current one

	assign last_step = step_en && (count == '0);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			count <= '0;
		end else if (load) begin
			count <= CW'(`MIPS_MUL_STEPS - 1);
		end else if (step_en) begin
			count <= count - 1'b1;
		end
	end

endmodule

//--- source/mips_sequencer.sv
`include "mips_consts.svh"

module mips_sequencer
	import mips_pkg::*;
(
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  not_empty,
	input  instr_t                head,
	output logic                  pop,
	output instr_t                ir,
	input  ctrl_t                 ctrl,
	input  logic [`MIPS_XLEN-1:0] alu_result,
	input  logic [`MIPS_XLEN-1:0] rt_data,
	input  logic [`MIPS_XLEN-1:0] product_hi,
	input  logic [`MIPS_XLEN-1:0] product_lo,
	input  logic                  last_step,
	output logic                  timer_load,
	output logic                  step_en,
	output logic                  mul_start,
	output logic [`MIPS_XLEN-1:0] operand_b,
	output logic                  wr_en,
	output logic [4:0]            wr_addr,
	output logic [`MIPS_XLEN-1:0] wr_data,
	output logic                  hi_we,
	output logic                  lo_we,
	output logic [`MIPS_XLEN-1:0] hi_in,
	output logic [`MIPS_XLEN-1:0] lo_in,
	output logic                  retire_valid,
	output retire_t               retire
);
	seq_state_e            state;
	seq_state_e            next_state;
	logic [`MIPS_XLEN-1:0] result_q; // ALU result captured in S_EXECUTE
	logic [15:0]           imm;
	logic [`MIPS_XLEN-1:0] imm_ext;
	logic                  wb;
	retire_kind_e          kind;

	assign imm        = {ir.rd, ir.shamt, ir.funct};
	assign imm_ext    = ctrl.zero_ext ? {{(`MIPS_XLEN-16){1'b0}}, imm}
	                                  : {{(`MIPS_XLEN-16){imm[15]}}, imm};
	assign operand_b  = ctrl.use_imm ? imm_ext : rt_data;
	assign pop        = (state == S_IDLE) && not_empty;
	assign mul_start  = (state == S_EXECUTE) && ctrl.mul;
	assign timer_load = mul_start;
	assign step_en    = (state == S_MUL_STEP);
	assign wb         = (state == S_WRITEBACK);
	assign wr_en      = wb && ctrl.reg_write;
	assign wr_addr    = ctrl.dst_rd ? ir.rd : ir.rt;
	assign wr_data    = result_q;
	assign hi_we      = wb && ctrl.hi_we;
	assign lo_we      = wb && ctrl.lo_we;
	assign hi_in      = ctrl.mul ? product_hi : result_q;
	assign lo_in      = ctrl.mul ? product_lo : result_q;

	always_comb begin
		if (ctrl.illegal) begin
			kind = RET_ILLEGAL;
		end else if (ctrl.hi_we && ctrl.lo_we) begin
			kind = RET_HILO;
		end else if (ctrl.hi_we) begin
			kind = RET_HI;
		end else if (ctrl.lo_we) begin
			kind = RET_LO;
		end else begin
			kind = RET_GPR;
		end
	end

	always_comb begin
		next_state = state;
		case (state)
			S_IDLE:     if (not_empty) next_state = S_EXECUTE;
			S_EXECUTE:  next_state = ctrl.mul ? S_MUL_STEP : S_WRITEBACK;
			S_MUL_STEP: if (last_step) next_state = S_WRITEBACK;
			default:    next_state = S_IDLE; // Writeback lasts one cycle
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state        <= S_IDLE;
			retire_valid <= 1'b0;
		end else begin
			state        <= next_state;
			retire_valid <= wb;
		end
	end

	always_ff @(posedge clk) begin
		if (pop) begin
			ir <= head;
		end
		if (state == S_EXECUTE) begin
			result_q <= alu_result;
		end
		if (wb) begin
			retire.kind    <= kind;
			retire.dest    <= (kind == RET_GPR) ? wr_addr : '0;
			retire.data_lo <= (ctrl.reg_write || ctrl.lo_we) ? lo_in : '0;
			retire.data_hi <= ctrl.hi_we ? hi_in : '0;
		end
	end

	// Every run of steps starts right after the timer was loaded
	assert property (@(posedge clk) disable iff (!rst_n)
		step_en |-> state == S_MUL_STEP && ($past(timer_load) || $past(step_en)));

endmodule

//--- source/mips_exec_top.sv
`include "mips_consts.svh"

module mips_exec_top
	import mips_pkg::*;
(
	input  logic    clk,
	input  logic    rst_n,
	input  logic    instr_valid,
	input  instr_t  instr,
	output logic    credit_return,
	output logic    retire_valid,
	output retire_t retire
);
	instr_t                head;
	instr_t                ir;
	ctrl_t                 ctrl;
	logic                  not_empty;
	logic                  pop;
	logic [`MIPS_XLEN-1:0] rs_data;
	logic [`MIPS_XLEN-1:0] rt_data;
	logic [`MIPS_XLEN-1:0] operand_b;
	logic [`MIPS_XLEN-1:0] alu_result;
	logic [`MIPS_XLEN-1:0] hi;
	logic [`MIPS_XLEN-1:0] lo;
	logic [`MIPS_XLEN-1:0] product_hi;
	logic [`MIPS_XLEN-1:0] product_lo;
	logic [`MIPS_XLEN-1:0] wr_data;
	logic [`MIPS_XLEN-1:0] hi_in;
	logic [`MIPS_XLEN-1:0] lo_in;
	logic [4:0]            wr_addr;
	logic                  wr_en;
	logic                  hi_we;
	logic                  lo_we;
	logic                  timer_load;
	logic                  step_en;
	logic                  mul_start;
	logic                  last_step;

	mips_instr_queue i_queue (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
		.pop(pop), .head(head), .not_empty(not_empty), .credit_return(credit_return)
	);

	mips_decoder i_decoder (.instr(ir), .ctrl(ctrl));

	mips_regfile i_regfile (
		.clk(clk), .rst_n(rst_n), .rs_addr(ir.rs), .rt_addr(ir.rt),
		.rs_data(rs_data), .rt_data(rt_data),
		.wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.hi_we(hi_we), .lo_we(lo_we), .hi_in(hi_in), .lo_in(lo_in), .hi(hi), .lo(lo)
	);

	mips_alu i_alu (
		.op(ctrl.alu_op), .a(rs_data), .b(operand_b), .shamt(ir.shamt),
		.hi(hi), .lo(lo), .result(alu_result)
	);

	mips_multiplier i_multiplier (
		.clk(clk), .rst_n(rst_n), .start(mul_start), .step_en(step_en),
		.signed_mul(ctrl.mul_signed), .a(rs_data), .b(rt_data),
		.product_hi(product_hi), .product_lo(product_lo)
	);

	mips_step_timer i_step_timer (
		.clk(clk), .rst_n(rst_n), .load(timer_load), .step_en(step_en),
		.last_step(last_step)
	);

	mips_sequencer i_sequencer (
		.clk(clk), .rst_n(rst_n), .not_empty(not_empty), .head(head), .pop(pop),
		.ir(ir), .ctrl(ctrl), .alu_result(alu_result), .rt_data(rt_data),
		.product_hi(product_hi), .product_lo(product_lo), .last_step(last_step),
		.timer_load(timer_load), .step_en(step_en), .mul_start(mul_start),
		.operand_b(operand_b), .wr_en(wr_en), .wr_addr(wr_addr), .wr_data(wr_data),
		.hi_we(hi_we), .lo_we(lo_we), .hi_in(hi_in), .lo_in(lo_in),
		.retire_valid(retire_valid), .retire(retire)
	);

endmodule

//--- bench/mips_exec_tb.sv
`include "mips_consts.svh"

module mips_exec_tb
	import mips_pkg::*;
();
	timeunit 1ns;
	timeprecision 100ps;

	localparam int CREDITS     = `MIPS_INSTR_CREDITS;
	localparam int MUL_LATENCY = `MIPS_MUL_STEPS + 2;
	localparam logic [5:0] ALU_FUNCTS [13] = '{F_ADD, F_ADDU, F_SUB, F_SUBU, F_AND, F_OR,
		F_XOR, F_NOR, F_SLT, F_SLTU, F_SLL, F_SRL, F_SRA}; // Shifts last
	localparam logic [5:0] IMM_OPS [8] = '{OP_ADDI, OP_ADDIU, OP_SLTI, OP_SLTIU, OP_ANDI,
		OP_ORI, OP_XORI, OP_LUI};
	localparam logic [5:0] ILLEGAL_OPS [8] = '{6'h02, 6'h03, 6'h04, 6'h05, 6'h20, 6'h23,
		6'h28, 6'h2b}; // j, jal, beq, bne, lb, lw, sb, sw

	logic    clk = 1'b0;
	logic    rst_n;
	logic    instr_valid;
	instr_t  instr;
	logic    credit_return;
	logic    retire_valid;
	retire_t retire;

	logic [31:0] gpr [32]; // Reference model state
	logic [31:0] model_hi;
	logic [31:0] model_lo;
	retire_t     exp_q [$];
	retire_t     exp_head;
	logic        exp_pending;
	logic        drain_check;
	int          want_latency;
	int          credits;
	int          in_flight;
	int          since_credit; // Cycles since the last credit_return
	int          errors;
	int          errors_at_start;
	int          retired;
	int          retired_at_start;
	int          tests_run;
	int          tests_failed;
	bit          timed_out;

	mips_exec_top i_mips_exec_top (
		.clk(clk), .rst_n(rst_n), .instr_valid(instr_valid), .instr(instr),
		.credit_return(credit_return), .retire_valid(retire_valid), .retire(retire)
	);

	always #2 clk = ~clk;

	assign want_latency = (exp_head.kind == RET_HILO) ? MUL_LATENCY : 2;

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			in_flight    <= 0;
			since_credit <= 0;
		end else begin
			in_flight    <= in_flight + int'(instr_valid) - int'(credit_return);
			since_credit <= credit_return ? 1 : since_credit + 1;
		end
	end

	assert property (@(posedge clk) disable iff (!rst_n) in_flight >= 0 && in_flight <= CREDITS)
		else begin
			errors++;
			$display("Credit count out of range at %0t ns: %0d outstanding", $time,
				$sampled(in_flight));
		end

	assert property (@(posedge clk) disable iff (!rst_n) retire_valid |-> exp_pending)
		else begin
			errors++;
			$display("Retire at %0t ns with no instruction outstanding", $time);
		end

	assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid && exp_pending |-> retire == exp_head)
		else begin
			errors++;
			$display("Mismatch at %0t ns: retire expected %h, got %h", $time,
				$sampled(exp_head), $sampled(retire));
		end

	// Also catches a pop while a multiply is still stepping
	assert property (@(posedge clk) disable iff (!rst_n)
		retire_valid && exp_pending |-> since_credit == want_latency)
		else begin
			errors++;
			$display("Mismatch at %0t ns: retire latency expected %0d, got %0d", $time,
				$sampled(want_latency), $sampled(since_credit));
		end

	assert property (@(posedge clk) disable iff (!rst_n) drain_check |-> in_flight == 0)
		else begin
			errors++;
			$display("Credits still outstanding at %0t ns after draining: %0d", $time,
				$sampled(in_flight));
		end

	function automatic instr_t r_op(logic [5:0] funct, logic [4:0] rd, logic [4:0] rs,
			logic [4:0] rt, logic [4:0] shamt);
		return instr_t'({6'h00, rs, rt, rd, shamt, funct});
	endfunction

	function automatic instr_t i_op(logic [5:0] op, logic [4:0] rt, logic [4:0] rs,
			logic [15:0] imm);
		return instr_t'({op, rs, rt, imm});
	endfunction

	function automatic logic [4:0] any_reg();
		return 5'($urandom_range(31, 1));
	endfunction

	function automatic instr_t random_alu();
		logic [31:0] bits;
		logic [3:0]  pick;
		logic [2:0]  ipick;
		bits  = $urandom;
		pick  = 4'($urandom_range(12));
		ipick = 3'($urandom_range(7));
		if ($urandom_range(2) == 0) begin // About a third immediate forms
			return i_op(IMM_OPS[ipick], bits[4:0], bits[9:5], bits[31:16]);
		end
		return r_op(ALU_FUNCTS[pick], bits[4:0], bits[9:5], bits[14:10],
			(pick >= 4'd10) ? bits[19:15] : 5'd0);
	endfunction

	// ISA semantics applied in program order
	function automatic retire_t predict_retire(instr_t w);
		retire_t     r;
		logic [31:0] s;
		logic [31:0] t;
		logic [15:0] imm;
		logic [31:0] imm_s;
		logic [63:0] p;
		s      = gpr[w.rs];
		t      = gpr[w.rt];
		imm    = {w.rd, w.shamt, w.funct};
		imm_s  = {{16{imm[15]}}, imm};
		r      = '0;
		r.kind = RET_GPR;
		r.dest = w.rt;
		case (w.op)
			OP_SPECIAL: begin
				r.dest = w.rd;
				case (w.funct)
					F_ADD, F_ADDU: r.data_lo = s + t;
					F_SUB, F_SUBU: r.data_lo = s - t;
					F_AND:         r.data_lo = s & t;
					F_OR:          r.data_lo = s | t;
					F_XOR:         r.data_lo = s ^ t;
					F_NOR:         r.data_lo = ~(s | t);
					F_SLT:         r.data_lo = {31'b0, $signed(s) < $signed(t)};
					F_SLTU:        r.data_lo = {31'b0, s < t};
					F_SLL:         r.data_lo = t << w.shamt;
					F_SRL:         r.data_lo = t >> w.shamt;
					F_SRA:         r.data_lo = $signed(t) >>> w.shamt;
					F_MFHI:        r.data_lo = model_hi;
					F_MFLO:        r.data_lo = model_lo;
					F_MTHI:        r = '{kind: RET_HI, dest: 5'd0, data_lo: 32'h0, data_hi: s};
					F_MTLO:        r = '{kind: RET_LO, dest: 5'd0, data_lo: s, data_hi: 32'h0};
					F_MULT, F_MULTU: begin
						p = (w.funct == F_MULT) ? {{32{s[31]}}, s} * {{32{t[31]}}, t}
						                        : {32'h0, s} * {32'h0, t};
						r = '{kind: RET_HILO, dest: 5'd0, data_lo: p[31:0], data_hi: p[63:32]};
					end
					default: r = '{kind: RET_ILLEGAL, dest: 5'd0, data_lo: 32'h0, data_hi: 32'h0};
				endcase
			end
			OP_ADDI, OP_ADDIU: r.data_lo = s + imm_s;
			OP_SLTI:           r.data_lo = {31'b0, $signed(s) < $signed(imm_s)};
			OP_SLTIU:          r.data_lo = {31'b0, s < imm_s};
			OP_ANDI:           r.data_lo = s & {16'h0, imm};
			OP_ORI:            r.data_lo = s | {16'h0, imm};
			OP_XORI:           r.data_lo = s ^ {16'h0, imm};
			OP_LUI:            r.data_lo = {imm, 16'h0};
			default:           r = '{kind: RET_ILLEGAL, dest: 5'd0, data_lo: 32'h0, data_hi: 32'h0};
		endcase
		case (r.kind)
			RET_GPR: begin
				if (r.dest != 5'd0) begin
					gpr[r.dest] = r.data_lo;
				end
			end
			RET_HI:   model_hi = r.data_hi;
			RET_LO:   model_lo = r.data_lo;
			RET_HILO: begin
				model_hi = r.data_hi;
				model_lo = r.data_lo;
			end
			default: ;
		endcase
		return r;
	endfunction

	task automatic refresh_expect();
		if (exp_q.size() != 0) begin
			exp_head    <= exp_q[0];
			exp_pending <= 1'b1;
		end else begin
			exp_head    <= '0;
			exp_pending <= 1'b0;
		end
	endtask

	// All stimulus time passes here, so no credit or retire pulse is missed
	task automatic tick();
		@(posedge clk);
		instr_valid <= 1'b0;
		if (credit_return) begin
			credits++;
		end
		if (retire_valid && exp_q.size() != 0) begin
			exp_q.delete(0);
			retired++;
			refresh_expect();
		end
	endtask

	task automatic send(input instr_t w);
		int waited;
		waited = 0;
		if (timed_out) begin
			return;
		end
		tick();
		while (credits == 0 && waited < 200) begin
			tick();
			waited++;
		end
		if (credits == 0) begin
			$display("Timeout at %0t ns: no credit came back within 200 cycles", $time);
			timed_out = 1'b1;
		end else begin
			instr_valid <= 1'b1;
			instr       <= w;
			credits--;
			exp_q.push_back(predict_retire(w));
			refresh_expect();
		end
	endtask

	task automatic finish_test(input string name);
		int waited;
		waited = 0;
		while (!timed_out && exp_q.size() != 0 && waited < 2000) begin
			tick();
			waited++;
		end
		if (!timed_out && exp_q.size() != 0) begin
			$display("Timeout at %0t ns: %0d instructions never retired", $time, exp_q.size());
			timed_out = 1'b1;
		end
		if (!timed_out) begin
			repeat (8) tick(); // Idle so every credit can come home
			drain_check <= 1'b1;
			tick();
			drain_check <= 1'b0;
			tick();
		end
		tests_run++;
		if (!timed_out && errors == errors_at_start) begin
			$display("%-14s ok, %0d retired", name, retired - retired_at_start);
		end else begin
			tests_failed++;
			$display("%-14s FAILED, %0d check errors", name, errors - errors_at_start);
		end
		errors_at_start  = errors;
		retired_at_start = retired;
	endtask

	task automatic credit_burst();
		logic [31:0] v;
		for (int r = 1; r < 32; r++) begin // Back to back until the credits run out
			v = $urandom;
			send(i_op(OP_LUI, 5'(r), 5'd0, v[31:16]));
			send(i_op(OP_ORI, 5'(r), 5'(r), v[15:0]));
		end
		finish_test("credit_burst");
	endtask

	task automatic reg_zero();
		send(i_op(OP_ADDIU, 5'd0, any_reg(), 16'h7fff));
		send(i_op(OP_LUI, 5'd0, 5'd0, 16'hdead));
		send(r_op(F_OR, 5'd0, any_reg(), any_reg(), 5'd0));
		send(r_op(F_ADDU, 5'd5, 5'd0, 5'd0, 5'd0));
		send(r_op(F_OR, 5'd6, 5'd0, any_reg(), 5'd0));
		send(r_op(F_SUBU, 5'd7, any_reg(), 5'd0, 5'd0));
		send(i_op(OP_ADDIU, 5'd8, 5'd0, 16'h8001));
		finish_test("reg_zero");
	endtask

	task automatic multiply();
		send(i_op(OP_LUI, 5'd30, 5'd0, 16'h8000)); // Most negative operand
		send(r_op(F_MULT, 5'd0, 5'd30, 5'd30, 5'd0));
		send(r_op(F_MULTU, 5'd0, 5'd30, 5'd30, 5'd0));
		send(r_op(F_MULT, 5'd0, 5'd0, any_reg(), 5'd0));
		repeat (12) begin
			send(r_op(($urandom_range(1) != 0) ? F_MULT : F_MULTU, 5'd0, any_reg(), any_reg(),
				5'd0));
			send(random_alu()); // Waits in the queue behind the multiply
			send(r_op(F_MFHI, any_reg(), 5'd0, 5'd0, 5'd0));
			send(r_op(F_MFLO, any_reg(), 5'd0, 5'd0, 5'd0));
		end
		finish_test("multiply");
	endtask

	task automatic hilo_moves();
		repeat (10) begin
			send(r_op(F_MTHI, 5'd0, any_reg(), 5'd0, 5'd0));
			send(r_op(F_MTLO, 5'd0, any_reg(), 5'd0, 5'd0));
			send(r_op(F_MFHI, any_reg(), 5'd0, 5'd0, 5'd0));
			send(r_op(F_MFLO, any_reg(), 5'd0, 5'd0, 5'd0));
		end
		finish_test("hilo_moves");
	endtask

	task automatic illegal_ops();
		logic [31:0] bits;
		send(r_op(F_MTHI, 5'd0, any_reg(), 5'd0, 5'd0));
		send(r_op(F_MTLO, 5'd0, any_reg(), 5'd0, 5'd0));
		repeat (16) begin
			bits = $urandom;
			send(instr_t'({ILLEGAL_OPS[3'($urandom_range(7))], bits[25:0]}));
		end
		for (int r = 1; r < 32; r++) begin // Read back through r0 to show no state change
			send(r_op(F_OR, 5'd0, 5'(r), 5'd0, 5'd0));
		end
		send(r_op(F_MFHI, 5'd0, 5'd0, 5'd0, 5'd0));
		send(r_op(F_MFLO, 5'd0, 5'd0, 5'd0, 5'd0));
		finish_test("illegal_ops");
	endtask

	initial begin
		void'($urandom(32'hec60b1ee));
		rst_n       = 1'b0;
		instr_valid = 1'b0;
		instr       = '0;
		exp_head    = '0;
		exp_pending = 1'b0;
		drain_check = 1'b0;
		credits     = CREDITS;
		model_hi    = '0;
		model_lo    = '0;
		for (int r = 0; r < 32; r++) begin
			gpr[r] = '0;
		end
		repeat (10) tick();
		rst_n <= 1'b1;
		tick();

		credit_burst();
		repeat (120) send(random_alu());
		finish_test("alu_random");
		reg_zero();
		multiply();
		hilo_moves();
		illegal_ops();

		$display("Summary: %0d tests run, %0d failed, %0d check errors, %0d retired",
			tests_run, tests_failed, errors, retired);
		if (tests_failed == 0 && errors == 0 && !timed_out) begin
			$display("test passed");
		end else begin
			$display("test failed");
		end
		$finish;
	end

endmodule

//--- vlog.f
+incdir+source
source/mips_pkg.sv
source/mips_instr_queue.sv
source/mips_decoder.sv
source/mips_alu.sv
source/mips_regfile.sv
source/mips_multiplier.sv
source/mips_step_timer.sv
source/mips_sequencer.sv
source/mips_exec_top.sv
bench/mips_exec_tb.sv

//--- Makefile
.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module mips_exec_tb -f vlog.f
	./obj_dir/Vmips_exec_tb | tee sim.log
	grep -qx "test passed" sim.log

clean:
	rm -rf obj_dir sim.log
